//--- source/exec_pkg.sv
/*
 * RV32I execute slice shared definitions
 * One-hot ALU operation, issue slot, micro-op and execute result
 * structs, opcode constants and the micro-op buffer sizing.
 */
package exec_pkg;

  localparam int XLEN       = 32;
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  // base opcodes handled by the slice
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct7 patterns
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // one-hot op, declared msb first so op_add lands on bit 0
  typedef struct packed {
    logic op_bgeu;
    logic op_bge;
    logic op_bltu;
    logic op_blt;
    logic op_bne;
    logic op_beq;
    logic op_lui;
    logic op_sra;
    logic op_srl;
    logic op_sll;
    logic op_xor;
    logic op_or;
    logic op_and;
    logic op_sltu;
    logic op_slt;
    logic op_sub;
    logic op_add;
  } alu_op_t;

  typedef enum logic [1:0] {
    SRC1_REG  = 2'd0,
    SRC1_PC   = 2'd1,
    SRC1_ZERO = 2'd2
  } src1_sel_t;

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
  } issue_t;

  typedef struct packed {
    alu_op_t         op;
    src1_sel_t       src1_sel;
    logic            src2_imm;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [4:0]      rd;
    logic            wb_en;
    logic            is_branch;
    logic            illegal;
  } uop_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            wb_en;
    logic [XLEN-1:0] result;
    logic            br_taken;
    logic [XLEN-1:0] next_pc;
    logic            overflow;
    logic            illegal;
  } exe_res_t;

endpackage

//--- source/rv_decoder.sv
/*
 * RV32I decoder
 * Registers one issue slot per strobe into a micro-op: one-hot ALU
 * op, operand selects, sign-extended I/U/B immediate and writeback
 * fields. Anything outside OP, OP-IMM, LUI, AUIPC and BRANCH, or a
 * bad funct field, comes out marked illegal with writeback off.
 */
module rv_decoder import exec_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   in_valid,
  input  issue_t in,
  output logic   uop_valid,
  output uop_t   uop
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_base;
  logic            f7_alt;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic            legal;
  uop_t            uop_next;

  assign opcode  = in.instr[6:0];
  assign funct3  = in.instr[14:12];
  assign funct7  = in.instr[31:25];
  assign f7_base = (funct7 == F7_BASE);
  assign f7_alt  = (funct7 == F7_ALT);

  assign imm_i = {{20{in.instr[31]}}, in.instr[31:20]};
  assign imm_u = {in.instr[31:12], 12'b0};
  assign imm_b = {{19{in.instr[31]}}, in.instr[31], in.instr[7],
                  in.instr[30:25], in.instr[11:8], 1'b0};

  always_comb begin
    uop_next         = '0;
    uop_next.pc      = in.pc;
    uop_next.rs1_val = in.rs1_val;
    uop_next.rs2_val = in.rs2_val;
    // rd is the raw field, wb_en decides whether it matters
    uop_next.rd      = in.instr[11:7];
    legal            = 1'b1;
    case (opcode)
      OPC_OP: begin
        uop_next.wb_en = 1'b1;
        // alt funct7 only exists for sub and sra
        if (!(f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))))
          legal = 1'b0;
        case (funct3)
          3'b000: begin
            uop_next.op.op_add = f7_base;
            uop_next.op.op_sub = f7_alt;
          end
          3'b001: uop_next.op.op_sll  = 1'b1;
          3'b010: uop_next.op.op_slt  = 1'b1;
          3'b011: uop_next.op.op_sltu = 1'b1;
          3'b100: uop_next.op.op_xor  = 1'b1;
          3'b101: begin
            uop_next.op.op_srl = f7_base;
            uop_next.op.op_sra = f7_alt;
          end
          3'b110: uop_next.op.op_or   = 1'b1;
          default: uop_next.op.op_and = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        uop_next.wb_en    = 1'b1;
        uop_next.src2_imm = 1'b1;
        uop_next.imm      = imm_i;
        case (funct3)
          3'b000: uop_next.op.op_add  = 1'b1;
          3'b010: uop_next.op.op_slt  = 1'b1;
          3'b011: uop_next.op.op_sltu = 1'b1;
          3'b100: uop_next.op.op_xor  = 1'b1;
          3'b110: uop_next.op.op_or   = 1'b1;
          3'b111: uop_next.op.op_and  = 1'b1;
          3'b001: begin
            uop_next.op.op_sll = 1'b1;
            legal              = f7_base;
          end
          default: begin
            // srli / srai, shamt sits in imm[4:0]
            uop_next.op.op_srl = f7_base;
            uop_next.op.op_sra = f7_alt;
            legal              = f7_base | f7_alt;
          end
        endcase
      end
      OPC_LUI: begin
        uop_next.wb_en     = 1'b1;
        uop_next.src1_sel  = SRC1_ZERO;
        uop_next.src2_imm  = 1'b1;
        uop_next.imm       = imm_u;
        uop_next.op.op_lui = 1'b1;
      end
      OPC_AUIPC: begin
        uop_next.wb_en     = 1'b1;
        uop_next.src1_sel  = SRC1_PC;
        uop_next.src2_imm  = 1'b1;
        uop_next.imm       = imm_u;
        uop_next.op.op_add = 1'b1;
      end
      OPC_BRANCH: begin
        // compare rs1 with rs2, target offset rides along in imm
        uop_next.is_branch = 1'b1;
        uop_next.imm       = imm_b;
        case (funct3)
          3'b000: uop_next.op.op_beq  = 1'b1;
          3'b001: uop_next.op.op_bne  = 1'b1;
          3'b100: uop_next.op.op_blt  = 1'b1;
          3'b101: uop_next.op.op_bge  = 1'b1;
          3'b110: uop_next.op.op_bltu = 1'b1;
          3'b111: uop_next.op.op_bgeu = 1'b1;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      uop_next.op        = '0;
      uop_next.wb_en     = 1'b0;
      uop_next.is_branch = 1'b0;
      uop_next.illegal   = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      uop_valid <= 1'b0;
    end else begin
      uop_valid <= in_valid;
    end
  end

  // payload only moves on a strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      uop <= uop_next;
    end
  end

endmodule

//--- source/uop_fifo.sv
/*
 * micro-op FIFO
 * Circular buffer of FIFO_DEPTH micro-ops with an occupancy count
 * for the full and empty levels. head shows the oldest entry.
 */
module uop_fifo import exec_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  uop_t wdata,
  input  logic pop,
  output uop_t head,
  output logic empty,
  output logic full
);

  uop_t               mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wptr;
  logic [FIFO_AW-1:0] rptr;
  logic [FIFO_AW:0]   count;

  assign head  = mem[rptr];
  assign empty = (count == '0);
  // a write already in flight from the decoder counts as taken, so a
  // strobe accepted while full is low always finds a free slot
  assign full  = ((count + {{FIFO_AW{1'b0}}, push}) >= (FIFO_AW+1)'(FIFO_DEPTH));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- source/alu.sv
/*
 * one-hot RV32I ALU
 * A single 33-bit adder does add, sub and every compare. Shifts use
 * src2[4:0]. The result is an AND-OR mux over the one-hot op;
 * overflow is reported for add and sub only.
 */
module alu import exec_pkg::*; (
  input  alu_op_t          alu_op,
  input  logic [XLEN-1:0]  alu_src1,
  input  logic [XLEN-1:0]  alu_src2,
  output logic [XLEN-1:0]  alu_result,
  output logic             integer_overflow
);

  logic            sub_mode;
  logic [XLEN-1:0] adder_b;
  logic [XLEN:0]   adder_sum;
  logic [XLEN-1:0] diff;
  logic            carry;
  logic            eq;
  logic            lt;
  logic            ltu;
  logic            cmp_bit;
  logic [4:0]      shamt;
  logic [XLEN-1:0] sll_result;
  logic [XLEN-1:0] srl_result;
  logic [XLEN-1:0] sra_result;

  // subtract for sub and for all compares
  assign sub_mode = alu_op.op_sub | alu_op.op_slt | alu_op.op_sltu
                  | alu_op.op_beq | alu_op.op_bne | alu_op.op_blt
                  | alu_op.op_bltu | alu_op.op_bge | alu_op.op_bgeu;

  assign adder_b   = sub_mode ? ~alu_src2 : alu_src2;
  assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b} + {{XLEN{1'b0}}, sub_mode};
  assign diff      = adder_sum[XLEN-1:0];
  assign carry     = adder_sum[XLEN];

  // carry out of a - b is set when a >= b unsigned
  assign eq  = (diff == '0);
  assign ltu = ~carry;
  // differing signs decide directly, otherwise the difference cannot overflow
  assign lt  = (alu_src1[XLEN-1] != alu_src2[XLEN-1]) ? alu_src1[XLEN-1]
                                                      : diff[XLEN-1];

  assign cmp_bit = (alu_op.op_slt  & lt)
                 | (alu_op.op_sltu & ltu)
                 | (alu_op.op_beq  & eq)
                 | (alu_op.op_bne  & ~eq)
                 | (alu_op.op_blt  & lt)
                 | (alu_op.op_bltu & ltu)
                 | (alu_op.op_bge  & ~lt)
                 | (alu_op.op_bgeu & ~ltu);

  // same-sign inputs to the adder giving the other sign
  assign integer_overflow = (alu_op.op_add | alu_op.op_sub)
                          & (alu_src1[XLEN-1] == adder_b[XLEN-1])
                          & (diff[XLEN-1] != alu_src1[XLEN-1]);

  assign shamt      = alu_src2[4:0];
  assign sll_result = alu_src1 << shamt;
  assign srl_result = alu_src1 >> shamt;
  assign sra_result = $unsigned($signed(alu_src1) >>> shamt);

  assign alu_result = ({XLEN{alu_op.op_add | alu_op.op_sub}} & diff)
                    | ({XLEN{alu_op.op_and}} & (alu_src1 & alu_src2))
                    | ({XLEN{alu_op.op_or }} & (alu_src1 | alu_src2))
                    | ({XLEN{alu_op.op_xor}} & (alu_src1 ^ alu_src2))
                    | ({XLEN{alu_op.op_sll}} & sll_result)
                    | ({XLEN{alu_op.op_srl}} & srl_result)
                    | ({XLEN{alu_op.op_sra}} & sra_result)
                    | ({XLEN{alu_op.op_lui}} & alu_src2)
                    | {{(XLEN-1){1'b0}}, cmp_bit};

endmodule

//--- source/exec_unit.sv
/*
 * execute unit
 * Pops the FIFO head whenever it is not empty and hold is low,
 * runs the ALU and registers writeback value, branch decision,
 * next pc and overflow one cycle after the pop.
 */
module exec_unit import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     empty,
  input  uop_t     head,
  output logic     pop,
  output logic     res_valid,
  output exe_res_t res
);

  logic [XLEN-1:0] alu_src1;
  logic [XLEN-1:0] alu_src2;
  logic [XLEN-1:0] alu_result;
  logic            integer_overflow;
  logic            taken;
  exe_res_t        res_next;

  assign pop = ~empty & ~hold;

  always_comb begin
    case (head.src1_sel)
      SRC1_PC:   alu_src1 = head.pc;
      SRC1_ZERO: alu_src1 = '0;
      default:   alu_src1 = head.rs1_val;
    endcase
  end

  assign alu_src2 = head.src2_imm ? head.imm : head.rs2_val;

  alu u_alu (
    .alu_op           (head.op),
    .alu_src1         (alu_src1),
    .alu_src2         (alu_src2),
    .alu_result       (alu_result),
    .integer_overflow (integer_overflow)
  );

  assign taken = head.is_branch & alu_result[0];

  always_comb begin
    res_next.rd       = head.rd;
    res_next.wb_en    = head.wb_en & ~head.illegal;
    // branches and illegal ops write nothing back
    res_next.result   = (head.is_branch | head.illegal) ? '0 : alu_result;
    res_next.br_taken = taken;
    res_next.next_pc  = head.pc + (taken ? head.imm : XLEN'(4));
    res_next.overflow = integer_overflow;
    res_next.illegal  = head.illegal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      res <= res_next;
    end
  end

endmodule

//--- source/exec_top.sv
/*
 * RV32I execute slice top
 * decoder -> micro-op FIFO -> execute unit, wiring only
 */
module exec_top import exec_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  issue_t   in,
  input  logic     hold,
  output logic     full,
  output logic     res_valid,
  output exe_res_t res
);

  logic uop_valid;
  uop_t uop;
  uop_t head;
  logic empty;
  logic pop;

  rv_decoder u_dec (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in        (in),
    .uop_valid (uop_valid),
    .uop       (uop)
  );

  uop_fifo u_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (uop_valid),
    .wdata (uop),
    .pop   (pop),
    .head  (head),
    .empty (empty),
    .full  (full)
  );

  exec_unit u_exu (
    .clk       (clk),
    .rst       (rst),
    .hold      (hold),
    .empty     (empty),
    .head      (head),
    .pop       (pop),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

//--- tb/exec_assert.sv
/*
 * execute slice protocol checks
 * Bound into exec_top. Watches the source strobe against full,
 * res_valid through reset, the FIFO levels and pop-to-result order.
 */
module exec_assert (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic full,
  input logic empty,
  input logic pop,
  input logic res_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  // source must wait while the buffer reports full
  strobe_not_full: assert property (@(posedge clk) disable iff (rst)
    !(in_valid && full))
    else $error("in_valid strobed while full");

  res_quiet_in_reset: assert property (@(posedge clk) rst |=> !res_valid)
    else $error("res_valid high during reset");

  levels_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(full && empty))
    else $error("full and empty high together");

  // every result comes from a pop one cycle earlier
  result_after_pop: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> $past(pop))
    else $error("res_valid without a pop");

endmodule

bind exec_top exec_assert u_checks (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .full      (full),
  .empty     (empty),
  .pop       (pop),
  .res_valid (res_valid)
);

//--- tb/exec_tb.sv
/*
 * execute slice testbench
 * Seeded random issue slots under random hold. A reference model
 * predicts each result from the RV32I rules, and a queue checks that
 * every slot yields exactly one result, in issue order.
 */
module exec_tb import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_SLOTS      = 2000;
  localparam int          TIMEOUT_CYCLES = NUM_SLOTS * 16;
  localparam logic [31:0] SEED           = 32'hd31c_b55e;

  logic     clk;
  logic     rst;
  logic     in_valid;
  issue_t   issue;
  logic     hold;
  logic     full;
  logic     res_valid;
  exe_res_t res;

  exe_res_t exp_q[$];
  int       checked = 0;
  int       cycles = 0;

  exec_top DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in        (issue),
    .hold      (hold),
    .full      (full),
    .res_valid (res_valid),
    .res       (res)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string field, input logic [31:0] got_v,
                                 input logic [31:0] exp_v);
    $display("FAIL t=%0t slot %0d field %s: got %h expected %h",
             $time, checked, field, got_v, exp_v);
    stop_on_failure();
  endtask

  task automatic check_result(input exe_res_t got, input exe_res_t exp);
    if (got.illegal !== exp.illegal)
      report_mismatch("illegal", 32'(got.illegal), 32'(exp.illegal));
    else if (got.rd !== exp.rd)
      report_mismatch("rd", 32'(got.rd), 32'(exp.rd));
    else if (got.wb_en !== exp.wb_en)
      report_mismatch("wb_en", 32'(got.wb_en), 32'(exp.wb_en));
    else if (got.result !== exp.result)
      report_mismatch("result", got.result, exp.result);
    else if (got.br_taken !== exp.br_taken)
      report_mismatch("br_taken", 32'(got.br_taken), 32'(exp.br_taken));
    else if (got.next_pc !== exp.next_pc)
      report_mismatch("next_pc", got.next_pc, exp.next_pc);
    else if (got.overflow !== exp.overflow)
      report_mismatch("overflow", 32'(got.overflow), 32'(exp.overflow));
  endtask

  task automatic compare_full(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t full level: got %b expected %b", $time, got, exp);
      stop_on_failure();
    end
  endtask

  function automatic logic add_overflow(input logic [31:0] a, input logic [31:0] b,
                                        input logic [31:0] s);
    return (a[31] == b[31]) && (s[31] != a[31]);
  endfunction

  // a - b overflows when the signs differ and the result flips from a
  function automatic logic sub_overflow(input logic [31:0] a, input logic [31:0] b,
                                        input logic [31:0] s);
    return (a[31] != b[31]) && (s[31] != a[31]);
  endfunction

  // reference model straight from the RV32I rules
  function automatic exe_res_t predict_result(input issue_t s);
    exe_res_t    r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] boff;
    logic [4:0]  shamt;
    logic        ok;
    logic        take;
    r     = '0;
    f3    = s.instr[14:12];
    f7    = s.instr[31:25];
    a     = s.rs1_val;
    b     = s.rs2_val;
    imm   = {{20{s.instr[31]}}, s.instr[31:20]};
    boff  = {{19{s.instr[31]}}, s.instr[31], s.instr[7], s.instr[30:25],
             s.instr[11:8], 1'b0};
    shamt = s.instr[24:20];
    ok    = 1'b1;
    take  = 1'b0;
    r.rd  = s.instr[11:7];
    case (s.instr[6:0])
      OPC_OP: begin
        r.wb_en = 1'b1;
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        case (f3)
          3'd0: begin
            r.result   = f7[5] ? a - b : a + b;
            r.overflow = f7[5] ? sub_overflow(a, b, r.result)
                               : add_overflow(a, b, r.result);
          end
          3'd1: r.result = a << b[4:0];
          3'd2: r.result = {31'b0, $signed(a) < $signed(b)};
          3'd3: r.result = {31'b0, a < b};
          3'd4: r.result = a ^ b;
          3'd5: r.result = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: r.result = a | b;
          default: r.result = a & b;
        endcase
      end
      OPC_OP_IMM: begin
        r.wb_en = 1'b1;
        case (f3)
          3'd0: begin
            r.result   = a + imm;
            r.overflow = add_overflow(a, imm, r.result);
          end
          3'd1: begin
            ok       = (f7 == 7'h00);
            r.result = a << shamt;
          end
          3'd2: r.result = {31'b0, $signed(a) < $signed(imm)};
          3'd3: r.result = {31'b0, a < imm};
          3'd4: r.result = a ^ imm;
          3'd5: begin
            ok       = (f7 == 7'h00) || (f7 == 7'h20);
            r.result = f7[5] ? $unsigned($signed(a) >>> shamt) : a >> shamt;
          end
          3'd6: r.result = a | imm;
          default: r.result = a & imm;
        endcase
      end
      OPC_LUI: begin
        r.wb_en  = 1'b1;
        r.result = {s.instr[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        r.wb_en    = 1'b1;
        r.result   = s.pc + {s.instr[31:12], 12'b0};
        r.overflow = add_overflow(s.pc, {s.instr[31:12], 12'b0}, r.result);
      end
      OPC_BRANCH: begin
        case (f3)
          3'd0: take = (a == b);
          3'd1: take = (a != b);
          3'd4: take = $signed(a) < $signed(b);
          3'd5: take = $signed(a) >= $signed(b);
          3'd6: take = a < b;
          3'd7: take = a >= b;
          default: ok = 1'b0;
        endcase
        r.br_taken = take;
      end
      default: ok = 1'b0;
    endcase
    r.next_pc = take ? s.pc + boff : s.pc + 32'd4;
    if (!ok) begin
      r         = '0;
      r.rd      = s.instr[11:7];
      r.illegal = 1'b1;
      r.next_pc = s.pc + 32'd4;
    end
    return r;
  endfunction

  // corner values half the time so overflow and compares get exercised
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = $urandom();
    case (r[2:0])
      3'd0: return 32'h0000_0000;
      3'd1: return 32'h8000_0000;
      3'd2: return 32'h7fff_ffff;
      3'd3: return 32'hffff_ffff;
      default: return $urandom();
    endcase
  endfunction

  function automatic logic [31:0] make_instr();
    logic [31:0] r;
    logic [31:0] w;
    logic [6:0]  f7;
    r = $urandom();
    w = $urandom();
    // a few raw words, mostly unsupported opcodes
    if (r[6:0] < 7'd6)
      return w;
    case (r[9:8])
      2'd1:    f7 = F7_ALT;
      2'd3:    f7 = r[16:10];
      default: f7 = F7_BASE;
    endcase
    case (r[19:17])
      3'd0, 3'd1: w = {f7, w[24:7], OPC_OP};
      3'd2, 3'd3: begin
        w[6:0] = OPC_OP_IMM;
        if (w[14:12] == 3'd1 || w[14:12] == 3'd5)
          w[31:25] = f7;
      end
      3'd4: w[6:0] = OPC_LUI;
      3'd5: w[6:0] = OPC_AUIPC;
      default: w[6:0] = OPC_BRANCH;
    endcase
    return w;
  endfunction

  function automatic issue_t make_slot();
    issue_t      s;
    logic [31:0] r;
    logic [31:0] p;
    r         = $urandom();
    p         = $urandom();
    s.instr   = make_instr();
    s.pc      = {p[31:2], 2'b00};
    s.rs1_val = pick_operand();
    // equal operands now and then for beq/bge
    s.rs2_val = (r[1:0] == 2'd0) ? s.rs1_val : pick_operand();
    return s;
  endfunction

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: results stopped arriving");
      stop_on_failure();
    end
  end

  // scoreboard, samples the values from before the edge
  always @(posedge clk) begin
    if (!rst && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("a result arrived with no issued slot waiting for it");
        stop_on_failure();
      end else begin
        check_result(res, exp_q.pop_front());
        checked = checked + 1;
      end
    end
  end

  initial begin
    issue_t      slot;
    logic [31:0] r;
    int          issued;
    int          occ;
    int          inflight;
    logic        prev_valid;
    logic        prev_hold;
    logic        popped;
    logic        full_now;
    void'($urandom(SEED));
    rst        = 1'b1;
    in_valid   = 1'b0;
    issue      = '0;
    hold       = 1'b0;
    issued     = 0;
    occ        = 0;
    inflight   = 0;
    prev_valid = 1'b0;
    prev_hold  = 1'b0;
    full_now   = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    while (issued < NUM_SLOTS) begin
      @(posedge clk);
      // full seen before this edge was predicted one cycle earlier
      compare_full(full, full_now);
      // buffer fill this cycle, counting the slot still in the decoder
      popped   = (occ != 0) && !prev_hold;
      occ      = occ + inflight - (popped ? 1 : 0);
      inflight = prev_valid ? 1 : 0;
      full_now = (occ + inflight) >= FIFO_DEPTH;
      r        = $urandom();
      slot     = make_slot();
      issue   <= slot;
      if (r[2:0] < 3'd5 && !full_now && !full) begin
        in_valid <= 1'b1;
        exp_q.push_back(predict_result(slot));
        issued     = issued + 1;
        prev_valid = 1'b1;
      end else begin
        in_valid  <= 1'b0;
        prev_valid = 1'b0;
      end
      if (r[7:4] == 4'd0)
        prev_hold = !prev_hold;
      hold <= prev_hold;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    hold     <= 1'b0;
    while (exp_q.size() != 0)
      @(posedge clk);
    repeat (10) @(posedge clk);
    if (exp_q.size() == 0 && checked == NUM_SLOTS) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("wrong result count: %0d of %0d slots checked", checked, NUM_SLOTS);
      stop_on_failure();
    end
  end

endmodule

//--- sim.f
source/exec_pkg.sv
source/rv_decoder.sv
source/uop_fifo.sv
source/alu.sv
source/exec_unit.sv
source/exec_top.sv
tb/exec_assert.sv
tb/exec_tb.sv

//--- run.sh
#!/bin/sh
# build the execute slice testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module exec_tb -f sim.f -o exec_sim &&
  ./obj_dir/exec_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
